//--- bench/program_patterns.mem
// hex words: test count, then per test program length (0 keeps last program), program words,
// four start values (core 0 first), check count, then address and expected value pairs
0004
// test 1: set_const, add, sub, and, or, xor stored at offsets 10..15
0013
a3c1 a10a a11b a12c 2013 3014 4015 5016
6017 a13d a14e a15f ca10 cb30 cc40 cd50
ce60 cf70 1000
1234 00f0 ffff 0007
0018
0010 003c 0011 1270 0012 11f8 0013 0034 0014 123c 0015 1208
0110 003c 0111 012c 0112 00b4 0113 0030 0114 00fc 0115 00cc
0210 003c 0211 003b 0212 ffc3 0213 003c 0214 ffff 0215 ffc3
0310 003c 0311 0043 0312 ffcb 0313 0004 0314 003f 0315 003b
// test 2: cmpge, lshift, rshift, then store, load back, add one, store
0018
a3c1 a032 a20a a21b 7013 8024 9025 a22c
a23d a01e ca30 cb40 cc50 cd00 bd06 a24f
0000 0000 26e7 0000 0000 0000 cf70 1000
0041 003c 003b 8123
0014
0020 0001 0021 0208 0022 0008 0023 0041 0024 0042
0120 0001 0121 01e0 0122 0007 0123 003c 0124 003d
0220 0000 0221 01d8 0222 0007 0223 003b 0224 003c
0320 0001 0321 0918 0322 1024 0323 8123 0324 8124
// test 3: bnz countdown sum stored at offset 30
000c
a012 a30a 0000 0000 2101 3020 0000 0000
0000 d040 ca10 1000
0005 000a 0003 0001
0004
0030 000f 0130 0037 0230 0006 0330 0001
// test 4: relaunch of the loop with new start values
0000
0007 0002 000c 0004
0004
0030 001c 0130 0003 0230 004e 0330 000a

//--- tb.f
hw/system_cfg_pkg.sv
hw/core_isa_pkg.sv
hw/alu.sv
hw/register_file.sv
hw/core.sv
hw/program_loader.sv
hw/shared_data_memory.sv
hw/many_core_top.sv
bench/tb_many_core.sv

//--- bench/tb_many_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_many_core
    import system_cfg_pkg::*;
();

    localparam int num_cores       = 4;
    localparam int cycles_per_test = 2000;
    localparam int pattern_depth   = 256;

    logic                     clk;
    logic                     reset;
    logic                     start;
    logic                     prog_we;
    logic [insn_ptr_size-1:0] prog_addr;
    logic [insn_size-1:0]     prog_data;
    logic                     r0_we;
    logic [core_id_size-1:0]  r0_core;
    logic [reg_size-1:0]      r0_data;
    logic [addr_size-1:0]     rd_addr;
    wire                      all_ready;
    wire  [reg_size-1:0]      rd_data;

    logic [15:0] patterns [pattern_depth];

    int error_count;
    int check_count;
    int test_total;
    int ptr;
    int prog_len;
    int check_total;
    int seed;
    int rnd;
    int cycle_limit;
    bit loaded;

    many_core_top #(
        .num_cores (num_cores)
    ) u_dut (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .r0_we     (r0_we),
        .r0_core   (r0_core),
        .r0_data   (r0_data),
        .all_ready (all_ready),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    always #5 clk = ~clk;

    task automatic idle_gap();
        int gap;
        gap = 1 + ($urandom % 8);
        repeat (gap) @(posedge clk);
    endtask

    task automatic write_program(input int base, input int count);
        for (int i = 0; i < count; i++)
        begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= insn_ptr_size'(i);
            prog_data <= patterns[base + i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
    endtask

    task automatic write_start_values(input int base);
        for (int c = 0; c < num_cores; c++)
        begin
            @(posedge clk);
            r0_we   <= 1'b1;
            r0_core <= core_id_size'(c);
            r0_data <= patterns[base + c];
        end
        @(posedge clk);
        r0_we <= 1'b0;
    endtask

    // one start pulse, then all_ready must fall and come back
    task automatic run_cores(input int test_idx);
        int wait_cycles;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        wait_cycles = 0;
        while (all_ready === 1'b1 && wait_cycles < 4)
        begin
            @(negedge clk);
            wait_cycles++;
        end
        if (all_ready !== 1'b0)
        begin
            $display("%0t test %0d: all_ready did not drop after start", $time, test_idx);
            error_count++;
        end
        else
        begin
            while (all_ready !== 1'b1)
                @(negedge clk);
        end
    endtask

    task automatic check_memory(input int base, input int count);
        logic [addr_size-1:0] check_addr;
        logic [reg_size-1:0]  expected;
        for (int i = 0; i < count; i++)
        begin
            check_addr = patterns[base + 2 * i][addr_size-1:0];
            expected   = patterns[base + 2 * i + 1];
            @(posedge clk);
            rd_addr <= check_addr;
            @(posedge clk);
            @(negedge clk); // read data lands one cycle after the address
            check_count++;
            if (rd_data !== expected)
            begin
                $display("[ERROR] %0t rd_data at 0x%03h: expected 0x%04h, got 0x%04h",
                         $time, check_addr, expected, rd_data);
                error_count++;
            end
        end
    endtask

    initial
    begin
        clk       = 1'b0;
        reset     = 1'b1;
        start     = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        r0_we     = 1'b0;
        r0_core   = '0;
        r0_data   = '0;
        rd_addr   = '0;
        error_count = 0;
        check_count = 0;
        seed = 70;
        rnd  = $urandom(seed);
        $readmemh("bench/program_patterns.mem", patterns);
        loaded = 1'b1;

        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        if (all_ready !== 1'b1)
        begin
            $display("[ERROR] %0t all_ready after reset: expected 1, got %b", $time, all_ready);
            error_count++;
        end

        test_total = patterns[0];
        if ($isunknown(patterns[0]))
        begin
            $display("pattern file could not be read");
            error_count++;
            test_total = 0;
        end

        ptr = 1;
        for (int t = 0; t < test_total; t++)
        begin
            prog_len = patterns[ptr];
            ptr++;
            if (prog_len > 0)
                write_program(ptr, prog_len); // zero length keeps the old program
            ptr += prog_len;
            write_start_values(ptr);
            ptr += num_cores;
            idle_gap();
            run_cores(t + 1);
            check_total = patterns[ptr];
            ptr++;
            check_memory(ptr, check_total);
            ptr += 2 * check_total;
            idle_gap();
        end

        $display("%0d tests, %0d checks, %0d errors", test_total, check_count, error_count);
        if (error_count == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

    initial
    begin
        wait (loaded);
        cycle_limit = patterns[0] * cycles_per_test;
        repeat (cycle_limit) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/many_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module many_core_top import system_cfg_pkg::*;
#(
    parameter int num_cores = 4
)
(
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      start,
    input  wire                      prog_we,
    input  wire  [insn_ptr_size-1:0] prog_addr,
    input  wire  [insn_size-1:0]     prog_data,
    input  wire                      r0_we,
    input  wire  [core_id_size-1:0]  r0_core,
    input  wire  [reg_size-1:0]      r0_data,
    output logic                     all_ready,
    input  wire  [addr_size-1:0]     rd_addr,
    output logic [reg_size-1:0]      rd_data
);

    logic                               launch;
    logic                               insn_we;
    logic [insn_ptr_size-1:0]           insn_addr;
    logic [insn_size-1:0]               insn_data;
    logic [num_cores-1:0][reg_size-1:0] init_r0_data;

    logic [num_cores-1:0]                core_ready;
    logic [num_cores-1:0][1:0]           enable;
    logic [num_cores-1:0][addr_size-1:0] addr;
    logic [num_cores-1:0][reg_size-1:0]  wr_data;
    logic [num_cores-1:0]                mem_ready;
    logic [reg_size-1:0]                 mem_rd_data;

    assign all_ready = &core_ready;

    program_loader #(
        .num_cores (num_cores)
    ) u_program_loader (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .all_ready    (all_ready),
        .prog_we      (prog_we),
        .prog_addr    (prog_addr),
        .prog_data    (prog_data),
        .r0_we        (r0_we),
        .r0_core      (r0_core),
        .r0_data      (r0_data),
        .launch       (launch),
        .insn_we      (insn_we),
        .insn_addr    (insn_addr),
        .insn_data    (insn_data),
        .init_r0_data (init_r0_data)
    );

    for (genvar i = 0; i < num_cores; i++)
    begin : g_core
        core #(
            .core_id (i)
        ) u_core (
            .clk          (clk),
            .reset        (reset),
            .launch       (launch),
            .init_r0_data (init_r0_data[i]),
            .insn_we      (insn_we),
            .insn_addr    (insn_addr),
            .insn_data    (insn_data),
            .ready        (core_ready[i]),
            .enable       (enable[i]),
            .addr         (addr[i]),
            .wr_data      (wr_data[i]),
            .mem_ready    (mem_ready[i]),
            .rd_data      (mem_rd_data)
        );
    end

    shared_data_memory #(
        .num_cores (num_cores)
    ) u_shared_data_memory (
        .clk          (clk),
        .reset        (reset),
        .enable       (enable),
        .addr         (addr),
        .wr_data      (wr_data),
        .mem_ready    (mem_ready),
        .rd_data      (mem_rd_data),
        .host_rd_addr (rd_addr),
        .host_rd_data (rd_data)
    );

endmodule

`default_nettype wire

//--- hw/shared_data_memory.sv
`timescale 1ns/1ps
`default_nettype none

module shared_data_memory import system_cfg_pkg::*;
#(
    parameter int num_cores = 4
)
(
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire  [num_cores-1:0][1:0]           enable,
    input  wire  [num_cores-1:0][addr_size-1:0] addr,
    input  wire  [num_cores-1:0][reg_size-1:0]  wr_data,
    output logic [num_cores-1:0]                mem_ready,
    output logic [reg_size-1:0]                 rd_data,
    input  wire  [addr_size-1:0]                host_rd_addr,
    output logic [reg_size-1:0]                 host_rd_data
);

    localparam int idx_size = (num_cores > 1) ? $clog2(num_cores) : 1;

    logic [reg_size-1:0] ram [2 ** addr_size];

    logic [num_cores-1:0] req;
    logic [idx_size-1:0]  last_grant;
    logic [idx_size-1:0]  grant_idx;
    logic                 grant_valid;
    int                   cand;

    // a core being answered this cycle still shows its old request
    always_comb
    begin
        for (int i = 0; i < num_cores; i++)
            req[i] = (enable[i] != 2'b00) && !mem_ready[i];
    end

    always_comb
    begin
        grant_valid = 1'b0;
        grant_idx   = last_grant;
        cand        = 0;
        for (int k = 1; k <= num_cores; k++)
        begin
            cand = (int'(last_grant) + k) % num_cores; // search after last winner
            if (!grant_valid && req[cand])
            begin
                grant_valid = 1'b1;
                grant_idx   = idx_size'(cand);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            mem_ready  <= '0;
            last_grant <= '0;
        end
        else
        begin
            mem_ready <= '0;
            if (grant_valid)
            begin
                mem_ready[grant_idx] <= 1'b1;
                last_grant           <= grant_idx;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (grant_valid && enable[grant_idx] == mem_wr)
            ram[addr[grant_idx]] <= wr_data[grant_idx];
        if (grant_valid && enable[grant_idx] == mem_rd)
            rd_data <= ram[addr[grant_idx]]; // common to all cores
        host_rd_data <= ram[host_rd_addr];
    end

endmodule

`default_nettype wire

//--- hw/program_loader.sv
`timescale 1ns/1ps
`default_nettype none

module program_loader import system_cfg_pkg::*;
#(
    parameter int num_cores = 4
)
(
    input  wire                                clk,
    input  wire                                reset,
    input  wire                                start,
    input  wire                                all_ready,
    input  wire                                prog_we,
    input  wire  [insn_ptr_size-1:0]           prog_addr,
    input  wire  [insn_size-1:0]               prog_data,
    input  wire                                r0_we,
    input  wire  [core_id_size-1:0]            r0_core,
    input  wire  [reg_size-1:0]                r0_data,
    output logic                               launch,
    output logic                               insn_we,
    output logic [insn_ptr_size-1:0]           insn_addr,
    output logic [insn_size-1:0]               insn_data,
    output logic [num_cores-1:0][reg_size-1:0] init_r0_data
);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            launch  <= 1'b0;
            insn_we <= 1'b0;
        end
        else
        begin
            launch  <= start && all_ready; // start while busy is dropped
            insn_we <= prog_we && all_ready;
        end
    end

    always_ff @(posedge clk)
    begin
        insn_addr <= prog_addr;
        insn_data <= prog_data;
        if (r0_we)
            init_r0_data[r0_core] <= r0_data; // start value table
    end

endmodule

`default_nettype wire

//--- hw/core.sv
`timescale 1ns/1ps
`default_nettype none

module core import system_cfg_pkg::*, core_isa_pkg::*;
#(
    parameter int core_id = 0
)
(
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      launch,
    input  wire  [reg_size-1:0]      init_r0_data,
    input  wire                      insn_we,
    input  wire  [insn_ptr_size-1:0] insn_addr,
    input  wire  [insn_size-1:0]     insn_data,
    output logic                     ready,
    output logic [1:0]               enable,
    output logic [addr_size-1:0]     addr,
    output logic [reg_size-1:0]      wr_data,
    input  wire                      mem_ready,
    input  wire  [reg_size-1:0]      rd_data
);

    localparam int offset_size = addr_size - core_id_size;

    logic [insn_size-1:0] insn_mem [insn_count];

    logic [insn_ptr_size-1:0] insn_ptr;
    logic                     block;

    logic [insn_size-1:0] fd_insn;
    logic [insn_size-1:0] dx_insn;
    logic [insn_size-1:0] xm_insn;
    logic [insn_size-1:0] mw_insn;

    logic [opc_size-1:0] fd_opc;
    logic [opc_size-1:0] dx_opc;
    logic [opc_size-1:0] xm_opc;
    logic [opc_size-1:0] mw_opc;

    logic [reg_size-1:0] rf_data_0;
    logic [reg_size-1:0] rf_data_1;
    logic [reg_size-1:0] dx_src_a;
    logic [reg_size-1:0] dx_src_b;
    logic [reg_size-1:0] alu_result;
    logic                branch_taken;
    logic [reg_size-1:0] x_result;
    logic [reg_size-1:0] xm_result;
    logic [reg_size-1:0] xm_store;
    logic [reg_size-1:0] mw_data;

    logic xm_is_ld;
    logic xm_is_st;
    logic mem_stall;
    logic wb_en;

    assign fd_opc = opc_of(fd_insn);
    assign dx_opc = opc_of(dx_insn);
    assign xm_opc = opc_of(xm_insn);
    assign mw_opc = opc_of(mw_insn);

    always_ff @(posedge clk)
    begin
        if (insn_we)
            insn_mem[insn_addr] <= insn_data;
    end

    register_file u_register_file (
        .clk          (clk),
        .reset        (reset),
        .clear        (launch),
        .init_r0      (launch),
        .init_r0_data (init_r0_data),
        .rd_sel_0     (src0_of(fd_insn)),
        .rd_sel_1     (src1_of(fd_insn)),
        .rd_data_0    (rf_data_0),
        .rd_data_1    (rf_data_1),
        .wr_en        (wb_en),
        .wr_sel       (dst_of(mw_insn)),
        .wr_data      (mw_data)
    );

    alu u_alu (
        .src_a        (dx_src_a),
        .src_b        (dx_src_b),
        .opc          (dx_opc),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    always_comb
    begin
        if (is_f2(dx_opc))
            x_result = const_of(dx_insn);
        else if (dx_opc == op_ld || dx_opc == op_st)
            x_result = dx_src_a; // address operand
        else
            x_result = alu_result;
    end

    assign xm_is_ld  = (xm_opc == op_ld);
    assign xm_is_st  = is_f3(xm_opc);
    assign enable    = xm_is_ld ? mem_rd : (xm_is_st ? mem_wr : 2'b00);
    assign addr      = {core_id_size'(core_id), xm_result[offset_size-1:0]};
    assign wr_data   = xm_store;
    assign mem_stall = (xm_is_ld || xm_is_st) && !mem_ready;

    assign wb_en = is_f1(mw_opc) || is_f2(mw_opc);

    always_ff @(posedge clk)
    begin
        if (reset || launch)
        begin
            insn_ptr <= '0;
            fd_insn  <= insn_nop;
            dx_insn  <= insn_nop;
            xm_insn  <= insn_nop;
            mw_insn  <= insn_nop;
            block    <= reset;  // idle until first launch
            ready    <= reset;
        end
        else
        begin
            if (mw_opc == op_ready)
                ready <= 1'b1;

            if (!mem_stall)
            begin
                if (branch_taken)
                begin
                    insn_ptr <= target_of(dx_insn);
                    fd_insn  <= insn_nop; // two bubbles
                    dx_insn  <= insn_nop;
                end
                else if (block)
                begin
                    dx_insn <= insn_nop;
                end
                else
                begin
                    insn_ptr <= insn_ptr + 1'b1;
                    if (insn_ptr == insn_ptr_size'(insn_count - 1))
                        fd_insn <= insn_ready; // end of program memory
                    else
                        fd_insn <= insn_mem[insn_ptr];
                    dx_insn <= fd_insn;
                end

                if (fd_opc == op_ready && !branch_taken)
                    block <= 1'b1;

                xm_insn <= dx_insn;
                mw_insn <= xm_insn;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!mem_stall)
        begin
            if (!is_f0(fd_opc))
            begin
                dx_src_a <= rf_data_0;
                dx_src_b <= rf_data_1;
            end
            xm_result <= x_result;
            xm_store  <= dx_src_b;
            mw_data   <= xm_is_ld ? rd_data : xm_result;
        end
    end

endmodule

`default_nettype wire

//--- hw/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file import system_cfg_pkg::*;
(
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     clear,
    input  wire                     init_r0,
    input  wire  [reg_size-1:0]     init_r0_data,
    input  wire  [reg_ptr_size-1:0] rd_sel_0,
    input  wire  [reg_ptr_size-1:0] rd_sel_1,
    output logic [reg_size-1:0]     rd_data_0,
    output logic [reg_size-1:0]     rd_data_1,
    input  wire                     wr_en,
    input  wire  [reg_ptr_size-1:0] wr_sel,
    input  wire  [reg_size-1:0]     wr_data
);

    localparam int reg_count = 2 ** reg_ptr_size;

    logic [reg_size-1:0] regs [reg_count];

    always_ff @(posedge clk)
    begin
        if (reset || clear)
        begin
            for (int i = 0; i < reg_count; i++)
                regs[i] <= '0;
        end
        else if (wr_en)
        begin
            regs[wr_sel] <= wr_data;
        end

        if (init_r0)
            regs[0] <= init_r0_data; // wins over the clear
    end

    // combinational read without bypass
    assign rd_data_0 = regs[rd_sel_0];
    assign rd_data_1 = regs[rd_sel_1];

endmodule

`default_nettype wire

//--- hw/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import system_cfg_pkg::*, core_isa_pkg::*;
(
    input  wire  [reg_size-1:0] src_a,
    input  wire  [reg_size-1:0] src_b,
    input  wire  [opc_size-1:0] opc,
    output logic [reg_size-1:0] result,
    output logic                branch_taken
);

    always_comb
    begin
        case (opc)
            op_add:
                result = src_a + src_b;
            op_sub:
                result = src_a - src_b;
            op_and:
                result = src_a & src_b;
            op_or:
                result = src_a | src_b;
            op_xor:
                result = src_a ^ src_b;
            op_cmpge:
                result = (src_a >= src_b) ? reg_size'(1) : '0; // unsigned compare
            op_lshift:
                result = src_a << src_b[3:0];
            op_rshift:
                result = src_a >> src_b[3:0];
            default:
                result = '0;
        endcase
    end

    // only bnz tests its operand
    assign branch_taken = is_f4(opc) && (src_a != '0);

endmodule

`default_nettype wire

//--- hw/core_isa_pkg.sv
`default_nettype none

package core_isa_pkg;
    import system_cfg_pkg::*;

    localparam int opc_size   = 4;
    localparam int opc_lsb    = 12;
    localparam int src0_lsb   = 8;
    localparam int src1_lsb   = 4;
    localparam int dst_lsb    = 0;
    localparam int target_lsb = 4; // overlaps src0 bit 8
    localparam int const_lsb  = 4;
    localparam int const_size = 8;

    localparam logic [opc_size-1:0] op_nop       = 4'h0;
    localparam logic [opc_size-1:0] op_ready     = 4'h1;
    localparam logic [opc_size-1:0] op_add       = 4'h2;
    localparam logic [opc_size-1:0] op_sub       = 4'h3;
    localparam logic [opc_size-1:0] op_and       = 4'h4;
    localparam logic [opc_size-1:0] op_or        = 4'h5;
    localparam logic [opc_size-1:0] op_xor       = 4'h6;
    localparam logic [opc_size-1:0] op_cmpge     = 4'h7;
    localparam logic [opc_size-1:0] op_lshift    = 4'h8;
    localparam logic [opc_size-1:0] op_rshift    = 4'h9;
    localparam logic [opc_size-1:0] op_set_const = 4'ha;
    localparam logic [opc_size-1:0] op_ld        = 4'hb;
    localparam logic [opc_size-1:0] op_st        = 4'hc;
    localparam logic [opc_size-1:0] op_bnz       = 4'hd;

    localparam logic [insn_size-1:0] insn_nop   = {op_nop, {(insn_size - opc_size){1'b0}}};
    localparam logic [insn_size-1:0] insn_ready = {op_ready, {(insn_size - opc_size){1'b0}}};

    function automatic logic [opc_size-1:0] opc_of(input logic [insn_size-1:0] insn);
        return insn[opc_lsb +: opc_size];
    endfunction

    function automatic logic [reg_ptr_size-1:0] src0_of(input logic [insn_size-1:0] insn);
        return insn[src0_lsb +: reg_ptr_size];
    endfunction

    function automatic logic [reg_ptr_size-1:0] src1_of(input logic [insn_size-1:0] insn);
        return insn[src1_lsb +: reg_ptr_size];
    endfunction

    function automatic logic [reg_ptr_size-1:0] dst_of(input logic [insn_size-1:0] insn);
        return insn[dst_lsb +: reg_ptr_size];
    endfunction

    function automatic logic [insn_ptr_size-1:0] target_of(input logic [insn_size-1:0] insn);
        return insn[target_lsb +: insn_ptr_size];
    endfunction

    function automatic logic [reg_size-1:0] const_of(input logic [insn_size-1:0] insn);
        return reg_size'(insn[const_lsb +: const_size]); // zero extended
    endfunction

    // format classes
    function automatic logic is_f0(input logic [opc_size-1:0] opc);
        return opc inside {op_nop, op_ready};
    endfunction

    function automatic logic is_f1(input logic [opc_size-1:0] opc);
        return opc inside {op_add, op_sub, op_and, op_or, op_xor, op_cmpge,
                           op_lshift, op_rshift, op_ld};
    endfunction

    function automatic logic is_f2(input logic [opc_size-1:0] opc);
        return opc == op_set_const;
    endfunction

    function automatic logic is_f3(input logic [opc_size-1:0] opc);
        return opc == op_st;
    endfunction

    function automatic logic is_f4(input logic [opc_size-1:0] opc);
        return opc == op_bnz;
    endfunction

endpackage

`default_nettype wire

//--- hw/system_cfg_pkg.sv
`default_nettype none

package system_cfg_pkg;

    localparam int reg_size      = 16;
    localparam int addr_size     = 10; // core id on top of register low bits
    localparam int core_id_size  = 2;
    localparam int insn_count    = 32;
    localparam int insn_size     = 16;
    localparam int insn_ptr_size = 5;
    localparam int reg_ptr_size  = 4;

    // memory request codes on the enable lines
    localparam logic [1:0] mem_rd = 2'b01;
    localparam logic [1:0] mem_wr = 2'b10;

endpackage

`default_nettype wire
